/* project.f */
logic/soc_bus_pkg.sv
logic/dev_map_pkg.sv
logic/core_req_slot.sv
logic/device_arbiter.sv
logic/dev_addr_decoder.sv
logic/device_bus_top.sv
verification/tb_clock_gen.sv
verification/tb_device_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module tb_device_bus -f project.f -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "Run aborted"; exit 1; }

grep -q "Something failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

/* verification/tb_device_bus.sv */
module tb_device_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED      = 47608;
    localparam int WAIT_MAX  = 200;            // Cycles before a wait gives up
    localparam int IDLE_CYC  = 20;
    localparam int RAND_REQS = 200;
    localparam soc_bus_pkg::data_t UART_XOR = 32'h5A5A_0F0F;   // Reset content of UART words
    localparam soc_bus_pkg::data_t SPI_XOR  = 32'h0F0F_A5A5;

    logic                              clk;
    logic                              usr_reset;
    logic [soc_bus_pkg::CORE_NUMS-1:0] core_strobe;
    soc_bus_pkg::addr_t                core_addr [soc_bus_pkg::CORE_NUMS];
    logic [soc_bus_pkg::CORE_NUMS-1:0] core_we;
    soc_bus_pkg::be_t                  core_be [soc_bus_pkg::CORE_NUMS];
    soc_bus_pkg::data_t                core_wdata [soc_bus_pkg::CORE_NUMS];
    logic [soc_bus_pkg::CORE_NUMS-1:0] core_ready;
    soc_bus_pkg::data_t                core_rdata [soc_bus_pkg::CORE_NUMS];
    soc_bus_pkg::addr_t                dev_addr;
    logic                              dev_we;
    soc_bus_pkg::be_t                  dev_be;
    soc_bus_pkg::data_t                dev_wdata;
    logic                              uart_strobe;
    logic                              uart_ready = 1'b0;
    soc_bus_pkg::data_t                uart_rdata = '0;
    logic                              spi_strobe;
    logic                              spi_ready = 1'b0;
    soc_bus_pkg::data_t                spi_rdata = '0;

    integer seed     = SEED;                   // Stimulus stream
    integer dev_seed = SEED;                   // Device delay stream
    soc_bus_pkg::data_t ref_mem [soc_bus_pkg::addr_t];
    soc_bus_pkg::data_t exp_q [soc_bus_pkg::CORE_NUMS][$];     // Filled at issue
    int    rd_idx [soc_bus_pkg::CORE_NUMS];    // Next entry the checker consumes
    int    served [$];                         // Cores in ready order
    int    chk_errors, chk_count, main_errors, err_base;
    int    tests_run, tests_passed, uart_pulses, spi_pulses;
    logic  hung = 1'b0;
    string cur_test = "reset";

    tb_clock_gen u_clk (.clk_o(clk));

    device_bus_top uut (
        .clk           (clk),
        .usr_reset     (usr_reset),
        .core_strobe_i (core_strobe),
        .core_addr_i   (core_addr),
        .core_we_i     (core_we),
        .core_be_i     (core_be),
        .core_wdata_i  (core_wdata),
        .core_ready_o  (core_ready),
        .core_rdata_o  (core_rdata),
        .dev_addr_o    (dev_addr),
        .dev_we_o      (dev_we),
        .dev_be_o      (dev_be),
        .dev_wdata_o   (dev_wdata),
        .uart_strobe_o (uart_strobe),
        .uart_ready_i  (uart_ready),
        .uart_rdata_i  (uart_rdata),
        .spi_strobe_o  (spi_strobe),
        .spi_ready_i   (spi_ready),
        .spi_rdata_i   (spi_rdata)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic is_mapped(input soc_bus_pkg::addr_t addr);
        return addr[31:24] == dev_map_pkg::UART_PREFIX || addr[31:24] == dev_map_pkg::SPI_PREFIX;
    endfunction

    // Expected read data for an address
    function automatic soc_bus_pkg::data_t ref_read(input soc_bus_pkg::addr_t addr);
        if (!is_mapped(addr))
            return '0;                         // Unmapped reads as zero
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return addr ^ ((addr[31:24] == dev_map_pkg::UART_PREFIX) ? UART_XOR : SPI_XOR);
    endfunction

    function automatic void ref_write(input soc_bus_pkg::addr_t addr,
                                      input soc_bus_pkg::be_t be, input soc_bus_pkg::data_t wdata);
        soc_bus_pkg::data_t merged;
        if (!is_mapped(addr))
            return;
        merged = ref_read(addr);
        for (int b = 0; b < 4; b++)
            if (be[b])
                merged[8*b +: 8] = wdata[8*b +: 8];   // Byte lane by lane
        ref_mem[addr] = merged;
    endfunction

    function automatic int total_errors();
        return chk_errors + main_errors;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < soc_bus_pkg::CORE_NUMS; i++)
            n += exp_q[i].size() - rd_idx[i];
        return n;
    endfunction

    // ------------------------------------------------------------
    // UART and SPI device models sharing one engine
    // ------------------------------------------------------------
    int                 dev_wait = 0;          // Cycles left until ready, 0 when idle
    logic               cap_spi, cap_we;
    soc_bus_pkg::addr_t cap_addr;
    soc_bus_pkg::be_t   cap_be;
    soc_bus_pkg::data_t cap_wdata;
    soc_bus_pkg::data_t uart_mem [soc_bus_pkg::addr_t];
    soc_bus_pkg::data_t spi_mem [soc_bus_pkg::addr_t];

    function automatic soc_bus_pkg::data_t dev_word(input logic spi, input soc_bus_pkg::addr_t a);
        if (spi)
            return spi_mem.exists(a) ? spi_mem[a] : a ^ SPI_XOR;
        return uart_mem.exists(a) ? uart_mem[a] : a ^ UART_XOR;
    endfunction

    always @(negedge clk) begin
        soc_bus_pkg::data_t word;
        soc_bus_pkg::data_t mask;
        uart_ready = 1'b0;                     // Ready is a single-cycle pulse
        spi_ready  = 1'b0;
        if (dev_wait != 0) begin
            dev_wait--;
            if (dev_wait == 0) begin
                word = dev_word(cap_spi, cap_addr);
                if (cap_we) begin
                    mask = {{8{cap_be[3]}}, {8{cap_be[2]}}, {8{cap_be[1]}}, {8{cap_be[0]}}};
                    word = (word & ~mask) | (cap_wdata & mask);
                    if (cap_spi)
                        spi_mem[cap_addr] = word;
                    else
                        uart_mem[cap_addr] = word;
                end
                if (cap_spi) begin
                    spi_ready = 1'b1;
                    spi_rdata = word;
                end else begin
                    uart_ready = 1'b1;
                    uart_rdata = word;
                end
            end
        end
        if (uart_strobe === 1'b1 || spi_strobe === 1'b1) begin
            cap_spi   = spi_strobe;            // Bus fields are held from the strobe on
            cap_addr  = dev_addr;
            cap_we    = dev_we;
            cap_be    = dev_be;
            cap_wdata = dev_wdata;
            dev_wait  = 1 + ($unsigned($random(dev_seed)) % 6);   // 1 to 6 cycles
        end
    end

    // ------------------------------------------------------------
    // Checker sampling outputs mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        for (int i = 0; i < soc_bus_pkg::CORE_NUMS; i++) begin
            if (core_ready[i] === 1'b1) begin
                if (rd_idx[i] >= exp_q[i].size()) begin
                    $display("Core %0d gave a ready with no request outstanding (%s)", i, cur_test);
                    chk_errors++;
                end else begin
                    chk_count++;
                    if (core_rdata[i] !== exp_q[i][rd_idx[i]]) begin
                        $display("FAILED %s: core %0d expected %h, actual %h",
                                 cur_test, i, exp_q[i][rd_idx[i]], core_rdata[i]);
                        chk_errors++;
                    end
                    rd_idx[i]++;
                    served.push_back(i);
                end
            end
        end
        if (uart_strobe === 1'b1)
            uart_pulses++;
        if (spi_strobe === 1'b1)
            spi_pulses++;
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        main_errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = total_errors();
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - err_base;
        tests_run++;
        if (n == 0) begin
            tests_passed++;
            $display("PASS  %s", cur_test);
        end else begin
            $display("FAIL  %s with %0d error(s)", cur_test, n);
        end
    endtask

    // Raises one core's strobe and queues the expected answer right away
    task automatic start_req(input int core, input logic we, input soc_bus_pkg::addr_t addr,
                             input soc_bus_pkg::be_t be, input soc_bus_pkg::data_t wdata);
        core_strobe[core] = 1'b1;
        core_addr[core]   = addr;
        core_we[core]     = we;
        core_be[core]     = be;
        core_wdata[core]  = wdata;
        if (we) begin
            exp_q[core].push_back('0);         // Writes answer with zero
            ref_write(addr, be, wdata);
        end else begin
            exp_q[core].push_back(ref_read(addr));
        end
    endtask

    task automatic wait_all_done();
        int cycles;
        cycles = 0;
        if (hung)
            return;
        while (outstanding() != 0 && cycles < WAIT_MAX) begin
            @(posedge clk);
            cycles++;
        end
        if (outstanding() != 0) begin
            $display("Timeout in %s: %0d request(s) got no ready within %0d cycles",
                     cur_test, outstanding(), WAIT_MAX);
            main_errors++;
            hung = 1'b1;
        end
    endtask

    task automatic do_request(input int core, input logic we, input soc_bus_pkg::addr_t addr,
                              input soc_bus_pkg::be_t be, input soc_bus_pkg::data_t wdata);
        @(negedge clk);
        start_req(core, we, addr, be, wdata);
        @(negedge clk);
        core_strobe = '0;                      // Strobe lasts one cycle
        wait_all_done();
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int u0, s0, base, core;
        logic [31:0] r;
        soc_bus_pkg::addr_t addr;
        usr_reset   = 1'b1;
        core_strobe = '0;
        core_we     = '0;
        for (int i = 0; i < soc_bus_pkg::CORE_NUMS; i++) begin
            core_addr[i]  = '0;
            core_be[i]    = '0;
            core_wdata[i] = '0;
        end
        repeat (4) @(negedge clk);
        usr_reset = 1'b0;

        // Quiet bus while the stretched reset runs out and after
        begin_test("idle after reset");
        for (int c = 0; c < IDLE_CYC; c++) begin
            @(negedge clk);
            if (uart_strobe !== 1'b0 || spi_strobe !== 1'b0 || core_ready !== '0) begin
                $display("Strobe or ready seen with no request at idle cycle %0d", c);
                main_errors++;
            end
        end
        end_test();

        begin_test("uart write and read");
        u0 = uart_pulses;
        s0 = spi_pulses;
        do_request(0, 1'b1, 32'hC000_0010, 4'hF, 32'hDEAD_BEEF);
        do_request(0, 1'b0, 32'hC000_0010, 4'hF, '0);
        if (uart_pulses - u0 != 2)
            report_value("uart strobes", 2, uart_pulses - u0);
        if (spi_pulses != s0)
            report_value("spi strobes", 0, spi_pulses - s0);
        end_test();

        begin_test("spi partial write");
        do_request(1, 1'b1, 32'hC200_0024, 4'b0110, 32'h1122_3344);
        if (cap_spi !== 1'b1)
            report_value("spi selected", 1, {31'h0, cap_spi});
        if (cap_addr !== 32'hC200_0024)
            report_value("dev_addr_o", 32'hC200_0024, cap_addr);
        if (cap_we !== 1'b1)
            report_value("dev_we_o", 1, {31'h0, cap_we});
        if (cap_be !== 4'b0110)
            report_value("dev_be_o", 32'h6, {28'h0, cap_be});
        if (cap_wdata !== 32'h1122_3344)
            report_value("dev_wdata_o", 32'h1122_3344, cap_wdata);
        do_request(1, 1'b0, 32'hC200_0024, 4'hF, '0);    // Merged value comes back
        end_test();

        // Core 3 so the next round-robin search starts at core 0
        begin_test("unmapped read");
        u0 = uart_pulses;
        s0 = spi_pulses;
        do_request(3, 1'b0, 32'h8000_0040, 4'hF, '0);
        if (uart_pulses != u0 || spi_pulses != s0)
            report_value("device strobes", 0, (uart_pulses - u0) + (spi_pulses - s0));
        end_test();

        begin_test("four cores at once");
        base = served.size();
        @(negedge clk);
        for (int i = 0; i < soc_bus_pkg::CORE_NUMS; i++)
            start_req(i, 1'b0, 32'hC000_0100 + 32'(i) * 32'h0200_0004, 4'hF, '0);
        @(negedge clk);
        core_strobe = '0;
        wait_all_done();
        if (served.size() - base != soc_bus_pkg::CORE_NUMS)
            report_value("ready count", soc_bus_pkg::CORE_NUMS, served.size() - base);
        else
            for (int k = 0; k < soc_bus_pkg::CORE_NUMS; k++)
                if (served[base + k] != k)
                    report_value("service order", k, served[base + k]);
        end_test();

        // Mostly UART and SPI with one in eight unmapped and 16 words per range
        begin_test("random requests");
        for (int n = 0; n < RAND_REQS; n++) begin
            r    = $random(seed);
            core = int'(r[13:12]);
            if (r[2:0] < 3'd4)
                addr = {dev_map_pkg::UART_PREFIX, 18'h0, r[11:8], 2'b00};
            else if (r[2:0] != 3'd7)
                addr = {dev_map_pkg::SPI_PREFIX, 18'h0, r[11:8], 2'b00};
            else
                addr = {8'h40, 18'h0, r[11:8], 2'b00};
            do_request(core, r[3], addr, r[7:4], $random(seed));
        end
        end_test();

        $display("Tests: %0d run, %0d passed, %0d failed; %0d data checks, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, chk_count, total_errors());
        if (total_errors() == 0 && !hung)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 5ns;         // 10 ns clock

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

/* logic/device_bus_top.sv */
module device_bus_top (
    input  logic                              clk,
    input  logic                              usr_reset,

    // Per-core device request ports
    input  logic [soc_bus_pkg::CORE_NUMS-1:0] core_strobe_i,
    input  soc_bus_pkg::addr_t                core_addr_i [soc_bus_pkg::CORE_NUMS],
    input  logic [soc_bus_pkg::CORE_NUMS-1:0] core_we_i,
    input  soc_bus_pkg::be_t                  core_be_i [soc_bus_pkg::CORE_NUMS],
    input  soc_bus_pkg::data_t                core_wdata_i [soc_bus_pkg::CORE_NUMS],
    output logic [soc_bus_pkg::CORE_NUMS-1:0] core_ready_o,
    output soc_bus_pkg::data_t                core_rdata_o [soc_bus_pkg::CORE_NUMS],

    // Shared device bus fields, common to both devices
    output soc_bus_pkg::addr_t                dev_addr_o,
    output logic                              dev_we_o,
    output soc_bus_pkg::be_t                  dev_be_o,
    output soc_bus_pkg::data_t                dev_wdata_o,

    // UART controller, off chip
    output logic                              uart_strobe_o,
    input  logic                              uart_ready_i,
    input  soc_bus_pkg::data_t                uart_rdata_i,

    // SPI controller, off chip
    output logic                              spi_strobe_o,
    input  logic                              spi_ready_i,
    input  soc_bus_pkg::data_t                spi_rdata_i
);

    logic                              sys_rst;
    logic [soc_bus_pkg::CORE_NUMS-1:0] pending;
    soc_bus_pkg::addr_t                held_addr [soc_bus_pkg::CORE_NUMS];
    logic [soc_bus_pkg::CORE_NUMS-1:0] held_we;
    soc_bus_pkg::be_t                  held_be [soc_bus_pkg::CORE_NUMS];
    soc_bus_pkg::data_t                held_wdata [soc_bus_pkg::CORE_NUMS];
    logic [soc_bus_pkg::CORE_NUMS-1:0] done;
    soc_bus_pkg::data_t                done_rdata;   // Shared, only done picks the owner
    logic                              bus_strobe;
    logic                              bus_ready;
    soc_bus_pkg::data_t                bus_rdata;

    // ------------------------------------------------------------
    // One request slot per core
    // ------------------------------------------------------------
    for (genvar i = 0; i < soc_bus_pkg::CORE_NUMS; i++) begin : g_slot
        core_req_slot u_slot (
            .clk          (clk),
            .rst_i        (sys_rst),
            .req_strobe_i (core_strobe_i[i]),
            .req_addr_i   (core_addr_i[i]),
            .req_we_i     (core_we_i[i]),
            .req_be_i     (core_be_i[i]),
            .req_wdata_i  (core_wdata_i[i]),
            .done_i       (done[i]),
            .done_rdata_i (done_rdata),
            .pending_o    (pending[i]),
            .held_addr_o  (held_addr[i]),
            .held_we_o    (held_we[i]),
            .held_be_o    (held_be[i]),
            .held_wdata_o (held_wdata[i]),
            .ready_o      (core_ready_o[i]),
            .rdata_o      (core_rdata_o[i])
        );
    end

    // ------------------------------------------------------------
    // Arbiter and address decoder
    // ------------------------------------------------------------
    device_arbiter u_arbiter (
        .clk          (clk),
        .usr_reset    (usr_reset),
        .sys_rst_o    (sys_rst),
        .pending_i    (pending),
        .slot_addr_i  (held_addr),
        .slot_we_i    (held_we),
        .slot_be_i    (held_be),
        .slot_wdata_i (held_wdata),
        .done_o       (done),
        .done_rdata_o (done_rdata),
        .bus_strobe_o (bus_strobe),
        .bus_addr_o   (dev_addr_o),
        .bus_we_o     (dev_we_o),
        .bus_be_o     (dev_be_o),
        .bus_wdata_o  (dev_wdata_o),
        .bus_ready_i  (bus_ready),
        .bus_rdata_i  (bus_rdata)
    );

    dev_addr_decoder u_decoder (
        .bus_strobe_i  (bus_strobe),
        .bus_addr_i    (dev_addr_o),
        .bus_ready_o   (bus_ready),
        .bus_rdata_o   (bus_rdata),
        .uart_strobe_o (uart_strobe_o),
        .uart_ready_i  (uart_ready_i),
        .uart_rdata_i  (uart_rdata_i),
        .spi_strobe_o  (spi_strobe_o),
        .spi_ready_i   (spi_ready_i),
        .spi_rdata_i   (spi_rdata_i)
    );

endmodule

/* logic/dev_addr_decoder.sv */
module dev_addr_decoder (
    // Shared device bus
    input  logic               bus_strobe_i,
    input  soc_bus_pkg::addr_t bus_addr_i,
    output logic               bus_ready_o,
    output soc_bus_pkg::data_t bus_rdata_o,

    // UART range
    output logic               uart_strobe_o,
    input  logic               uart_ready_i,
    input  soc_bus_pkg::data_t uart_rdata_i,

    // SPI range
    output logic               spi_strobe_o,
    input  logic               spi_ready_i,
    input  soc_bus_pkg::data_t spi_rdata_i
);

    dev_map_pkg::dev_prefix_t prefix;
    logic                     uart_sel;
    logic                     spi_sel;

    // ------------------------------------------------------------
    // Range match on the top address byte
    // ------------------------------------------------------------
    assign prefix   = bus_addr_i[soc_bus_pkg::XLEN-1 -: dev_map_pkg::DEV_PREFIX_W];
    assign uart_sel = (prefix == dev_map_pkg::UART_PREFIX);
    assign spi_sel  = (prefix == dev_map_pkg::SPI_PREFIX);

    // Only the addressed device sees the strobe
    assign uart_strobe_o = bus_strobe_i & uart_sel;
    assign spi_strobe_o  = bus_strobe_i & spi_sel;

    // ------------------------------------------------------------
    // Answer mux
    // ------------------------------------------------------------
    // Unmapped space answers right away so the bus never hangs
    assign bus_ready_o = uart_sel ? uart_ready_i :
                         spi_sel  ? spi_ready_i  :
                                    1'b1;

    assign bus_rdata_o = uart_sel ? uart_rdata_i :
                         spi_sel  ? spi_rdata_i  :
                                    '0;           // Unmapped reads as zero

endmodule

/* logic/device_arbiter.sv */
module device_arbiter (
    input  logic                                 clk,
    input  logic                                 usr_reset,
    output logic                                 sys_rst_o,

    // Slot side
    input  logic [soc_bus_pkg::CORE_NUMS-1:0]    pending_i,
    input  soc_bus_pkg::addr_t                   slot_addr_i [soc_bus_pkg::CORE_NUMS],
    input  logic [soc_bus_pkg::CORE_NUMS-1:0]    slot_we_i,
    input  soc_bus_pkg::be_t                     slot_be_i [soc_bus_pkg::CORE_NUMS],
    input  soc_bus_pkg::data_t                   slot_wdata_i [soc_bus_pkg::CORE_NUMS],
    output logic [soc_bus_pkg::CORE_NUMS-1:0]    done_o,
    output soc_bus_pkg::data_t                   done_rdata_o,

    // Shared device bus
    output logic                                 bus_strobe_o,
    output soc_bus_pkg::addr_t                   bus_addr_o,
    output logic                                 bus_we_o,
    output soc_bus_pkg::be_t                     bus_be_o,
    output soc_bus_pkg::data_t                   bus_wdata_o,
    input  logic                                 bus_ready_i,
    input  soc_bus_pkg::data_t                   bus_rdata_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,                              // Looking for a pending slot
        ARB_ISSUE,                             // Bus strobe high this cycle
        ARB_WAIT                               // Waiting for device ready
    } arb_state_t;

    arb_state_t                              state;
    logic [dev_map_pkg::RST_STRETCH-1:0]     rst_sr;
    soc_bus_pkg::core_id_t                   last_grant;   // Round-robin pointer
    soc_bus_pkg::core_id_t                   grant_id;     // Owner of the bus
    soc_bus_pkg::core_id_t                   pick_id;
    logic                                    pick_found;
    logic [soc_bus_pkg::CORE_NUMS-1:0]       eligible;

    // ------------------------------------------------------------
    // Reset stretcher
    // ------------------------------------------------------------
    // Ones flush out one per cycle once usr_reset is released
    always_ff @(posedge clk) begin
        if (usr_reset)
            rst_sr <= '1;
        else
            rst_sr <= {rst_sr[dev_map_pkg::RST_STRETCH-2:0], 1'b0};
    end

    assign sys_rst_o = rst_sr[dev_map_pkg::RST_STRETCH-1];

    // ------------------------------------------------------------
    // Round-robin pick
    // ------------------------------------------------------------
    // The slot just served still shows pending while done_o is high
    assign eligible = pending_i & ~done_o;

    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_id    = '0;
        for (int k = 1; k <= soc_bus_pkg::CORE_NUMS; k++) begin
            idx = (int'(last_grant) + k) % soc_bus_pkg::CORE_NUMS;   // One past last
            if (!pick_found && eligible[idx]) begin
                pick_found = 1'b1;
                pick_id    = soc_bus_pkg::core_id_t'(idx);
            end
        end
    end

    // ------------------------------------------------------------
    // Transfer FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sys_rst_o) begin
            state        <= ARB_IDLE;
            last_grant   <= soc_bus_pkg::core_id_t'(soc_bus_pkg::CORE_NUMS - 1);
            grant_id     <= '0;
            bus_strobe_o <= 1'b0;
            done_o       <= '0;
        end else begin
            done_o <= '0;                      // Done is a single pulse
            case (state)
                ARB_IDLE: begin
                    if (pick_found) begin
                        grant_id     <= pick_id;
                        last_grant   <= pick_id;
                        bus_strobe_o <= 1'b1;
                        state        <= ARB_ISSUE;
                    end
                end
                ARB_ISSUE: begin
                    bus_strobe_o <= 1'b0;      // Strobe lasts one cycle
                    state        <= ARB_WAIT;
                end
                ARB_WAIT: begin
                    if (bus_ready_i) begin
                        done_o[grant_id] <= 1'b1;   // Route back to the owner
                        state            <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Bus fields held for the whole transfer, read data latched with ready
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && pick_found) begin
            bus_addr_o  <= slot_addr_i[pick_id];
            bus_we_o    <= slot_we_i[pick_id];
            bus_be_o    <= slot_be_i[pick_id];
            bus_wdata_o <= slot_wdata_i[pick_id];
        end
        if (state == ARB_WAIT && bus_ready_i)
            done_rdata_o <= bus_rdata_i;
    end

endmodule

/* logic/core_req_slot.sv */
module core_req_slot (
    input  logic               clk,
    input  logic               rst_i,          // Stretched system reset

    // Core side request, valid only with the strobe
    input  logic               req_strobe_i,
    input  soc_bus_pkg::addr_t req_addr_i,
    input  logic               req_we_i,
    input  soc_bus_pkg::be_t   req_be_i,
    input  soc_bus_pkg::data_t req_wdata_i,

    // Completion from the arbiter
    input  logic               done_i,         // One-cycle pulse, this slot only
    input  soc_bus_pkg::data_t done_rdata_i,

    // Held request toward the arbiter
    output logic               pending_o,
    output soc_bus_pkg::addr_t held_addr_o,
    output logic               held_we_o,
    output soc_bus_pkg::be_t   held_be_o,
    output soc_bus_pkg::data_t held_wdata_o,

    // Answer toward the core
    output logic               ready_o,        // One cycle after done_i
    output soc_bus_pkg::data_t rdata_o
);

    // ------------------------------------------------------------
    // Pending flag and ready pulse
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_o <= 1'b0;
            ready_o   <= 1'b0;
        end else begin
            ready_o <= done_i;                 // Ready trails done by one edge
            if (done_i)
                pending_o <= 1'b0;             // Falls together with ready
            else if (req_strobe_i)
                pending_o <= 1'b1;             // Visible from the next cycle
        end
    end

    // ------------------------------------------------------------
    // Request and answer payload
    // ------------------------------------------------------------
    // Fields stay put while the slot waits, even when the bus stalls
    always_ff @(posedge clk) begin
        if (req_strobe_i) begin
            held_addr_o  <= req_addr_i;
            held_we_o    <= req_we_i;
            held_be_o    <= req_be_i;
            held_wdata_o <= req_wdata_i;
        end
        if (done_i)
            rdata_o <= held_we_o ? '0 : done_rdata_i;   // Writes return zero
    end

endmodule

/* logic/dev_map_pkg.sv */
package dev_map_pkg;

    // ------------------------------------------------------------
    // Device address map
    // ------------------------------------------------------------
    // Top address bits pick the device, the rest is device-local
    localparam int DEV_PREFIX_W = 8;

    typedef logic [DEV_PREFIX_W-1:0] dev_prefix_t;

    // 0xC000_0000 - 0xC0FF_FFFF
    localparam dev_prefix_t UART_PREFIX = 8'hC0;   // UART registers

    // 0xC200_0000 - 0xC2FF_FFFF
    localparam dev_prefix_t SPI_PREFIX = 8'hC2;    // SD card SPI registers

    // Everything else is unmapped and answered at once with zero

    // ------------------------------------------------------------
    // System reset
    // ------------------------------------------------------------
    // Cycles the system reset stays high after usr_reset drops
    localparam int RST_STRETCH = 5;

endpackage

/* logic/soc_bus_pkg.sv */
package soc_bus_pkg;

    // ------------------------------------------------------------
    // Core count and indexing
    // ------------------------------------------------------------
    localparam int CORE_NUMS = 4;              // Cores sharing the device bus
    localparam int CORE_ID_W = 2;              // Enough bits to name every core

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int XLEN = 32;                  // Data and address width

    // Bus data word, both directions
    typedef logic [XLEN-1:0] data_t;

    // Byte address as issued by a core
    typedef logic [XLEN-1:0] addr_t;

    // One enable per byte lane
    typedef logic [XLEN/8-1:0] be_t;

    // Core index, used by the arbiter for grant bookkeeping
    typedef logic [CORE_ID_W-1:0] core_id_t;

endpackage
